// ==== source/axil_pkg.sv ====
// AXI-lite widths, data types and response codes
package axil_pkg;

	// Byte address, data word and strobe widths
	localparam int AXIL_ADDR_W = 28;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [AXIL_DATA_W-1:0] axil_data_t;
	typedef logic [AXIL_STRB_W-1:0] axil_strb_t;

	// Two-bit response field on R and B
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	// Slave saw the access and rejected it
	localparam axil_resp_t RESP_SLVERR = 2'b10;
	// Read dropped during an error flush
	localparam axil_resp_t RESP_DECERR = 2'b11;

endpackage

// ==== source/wb_pkg.sv ====
// Wishbone widths, RAM depth and read FIFO depth
package wb_pkg;

	// Word address, two byte bits shorter than the AXI byte address
	localparam int WB_ADDR_W = 26;

	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [3:0]           wb_sel_t;

	// RAM depth in words; word addresses at or above this get err
	localparam int WB_MEM_WORDS = 256;

	// log2 of the read response FIFO depth (8 reads in flight)
	localparam int RD_LGFIFO = 3;

endpackage

// ==== source/wb_bus_if.sv ====
// Wishbone pipelined bus interface with master and slave modports
`timescale 1ns/1ps

interface wb_bus_if
	import axil_pkg::*, wb_pkg::*;
	();

	// Request side
	logic       cyc;
	logic       stb;
	logic       we;
	wb_addr_t   addr;
	axil_data_t wdata;
	wb_sel_t    sel;

	// Reply side
	axil_data_t rdata;
	logic       ack;
	logic       stall;
	logic       err;

	modport master (
		output cyc, stb, we, addr, wdata, sel,
		input  rdata, ack, stall, err
	);

	modport slave (
		input  cyc, stb, we, addr, wdata, sel,
		output rdata, ack, stall, err
	);

endinterface

// ==== source/axil_rd_bridge.sv ====
// AXI-lite read channel to pipelined Wishbone master with in-order response FIFO
`timescale 1ns/1ps

module axil_rd_bridge
	import axil_pkg::*, wb_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  axil_addr_t i_araddr,
	input  logic       i_arvalid,
	output logic       o_arready,
	output axil_data_t o_rdata,
	output axil_resp_t o_rresp,
	output logic       o_rvalid,
	input  logic       i_rready,
	wb_bus_if.master   wb
);

	// first: AR accepted, mid: reply captured, last: R delivered
	logic [RD_LGFIFO:0] r_first;
	logic [RD_LGFIFO:0] r_mid;
	logic [RD_LGFIFO:0] r_last;
	logic [RD_LGFIFO:0] fifo_fill;
	logic [RD_LGFIFO:0] outstanding;

	axil_data_t data_fifo [1 << RD_LGFIFO];
	axil_resp_t resp_fifo [1 << RD_LGFIFO];

	logic     stb_q;
	wb_addr_t addr_q;
	logic     shadow_valid;
	wb_addr_t shadow_addr;
	logic     err_state;

	logic ar_fire, r_fire, cyc, wb_accept, wb_reply, wb_fail, flush_step;

	assign ar_fire    = i_arvalid && o_arready;
	assign r_fire     = o_rvalid && i_rready;
	assign cyc        = stb_q || (outstanding != '0);
	assign wb_accept  = stb_q && !wb.stall;
	assign wb_reply   = cyc && (wb.ack || wb.err);
	assign wb_fail    = cyc && wb.err;
	assign flush_step = err_state && (r_mid != r_first);
	assign fifo_fill  = r_first - r_last;

	////////////////////
	// Wishbone request side
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || wb_fail || err_state)
			stb_q <= 1'b0;
		else if (shadow_valid || ar_fire)
			stb_q <= 1'b1;
		else if (!wb.stall)
			stb_q <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (shadow_valid && !wb.stall)
			addr_q <= shadow_addr;
		else if (ar_fire && (!stb_q || !wb.stall))
			addr_q <= i_araddr[AXIL_ADDR_W-1:2];
	end

	// Holds one address that arrived while stb was stalled
	always_ff @(posedge i_clk)
	begin
		if (i_reset || wb_fail || err_state)
			shadow_valid <= 1'b0;
		else if (ar_fire && stb_q && wb.stall)
			shadow_valid <= 1'b1;
		else if (!wb.stall)
			shadow_valid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (ar_fire && stb_q && wb.stall)
			shadow_addr <= i_araddr[AXIL_ADDR_W-1:2];
	end

	// Keeps cyc up until the last reply is back
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !cyc || wb_fail || err_state)
			outstanding <= '0;
		else
		begin
			case ({wb_accept, wb.ack})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	////////////////////
	// Pointers and error flush
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_first   <= '0;
			r_mid     <= '0;
			r_last    <= '0;
			err_state <= 1'b0;
		end
		else
		begin
			if (ar_fire)
				r_first <= r_first + 1'b1;
			if (wb_reply || flush_step)
				r_mid <= r_mid + 1'b1;
			if (r_fire)
				r_last <= r_last + 1'b1;
			if (wb_fail)
				err_state <= 1'b1;
			else if (r_first == r_last)
				err_state <= 1'b0;
		end
	end

	// The failing slot gets SLVERR, slots still queued behind it DECERR
	always_ff @(posedge i_clk)
	begin
		if (wb_reply)
		begin
			data_fifo[r_mid[RD_LGFIFO-1:0]] <= wb.rdata;
			resp_fifo[r_mid[RD_LGFIFO-1:0]] <= wb.err ? RESP_SLVERR : RESP_OKAY;
		end
		else if (flush_step)
			resp_fifo[r_mid[RD_LGFIFO-1:0]] <= RESP_DECERR;
	end

	// Full FIFO, waiting shadow or error flush block new addresses
	assign o_arready = !fifo_fill[RD_LGFIFO] && !shadow_valid && !err_state;
	assign o_rvalid  = (r_mid != r_last);
	assign o_rdata   = data_fifo[r_last[RD_LGFIFO-1:0]];
	assign o_rresp   = resp_fifo[r_last[RD_LGFIFO-1:0]];

	assign wb.cyc   = cyc;
	assign wb.stb   = stb_q;
	assign wb.we    = 1'b0;
	assign wb.addr  = addr_q;
	assign wb.wdata = '0;
	assign wb.sel   = '1;

endmodule

// ==== source/axil_wr_bridge.sv ====
// AXI-lite AW, W and B channels to a single-transaction Wishbone write master
`timescale 1ns/1ps

module axil_wr_bridge
	import axil_pkg::*, wb_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  axil_addr_t i_awaddr,
	input  logic       i_awvalid,
	output logic       o_awready,
	input  axil_data_t i_wdata,
	input  axil_strb_t i_wstrb,
	input  logic       i_wvalid,
	output logic       o_wready,
	output axil_resp_t o_bresp,
	output logic       o_bvalid,
	input  logic       i_bready,
	wb_bus_if.master   wb
);

	logic       aw_full;
	logic       w_full;
	wb_addr_t   aw_word;
	axil_data_t w_data;
	axil_strb_t w_strb;

	logic       cyc_q;
	logic       stb_q;
	logic       bvalid_q;
	axil_resp_t bresp_q;

	logic aw_fire, w_fire, b_fire, wb_reply;

	assign aw_fire  = i_awvalid && o_awready;
	assign w_fire   = i_wvalid && o_wready;
	assign b_fire   = bvalid_q && i_bready;
	assign wb_reply = cyc_q && (wb.ack || wb.err);

	////////////////////
	// Holding registers
	////////////////////

	// Each side drops its ready after its own handshake
	always_ff @(posedge i_clk)
	begin
		if (i_reset || b_fire)
		begin
			aw_full <= 1'b0;
			w_full  <= 1'b0;
		end
		else
		begin
			if (aw_fire)
				aw_full <= 1'b1;
			if (w_fire)
				w_full <= 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (aw_fire)
			aw_word <= i_awaddr[AXIL_ADDR_W-1:2];
		if (w_fire)
		begin
			w_data <= i_wdata;
			w_strb <= i_wstrb;
		end
	end

	////////////////////
	// Wishbone write and B response
	////////////////////

	// Issue once both halves are held and no response is pending
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
		end
		else if (!cyc_q && aw_full && w_full && !bvalid_q)
		begin
			cyc_q <= 1'b1;
			stb_q <= 1'b1;
		end
		else
		begin
			if (stb_q && !wb.stall)
				stb_q <= 1'b0;
			if (wb_reply)
				cyc_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			bvalid_q <= 1'b0;
		else if (wb_reply)
			bvalid_q <= 1'b1;
		else if (b_fire)
			bvalid_q <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (wb_reply)
			bresp_q <= wb.err ? RESP_SLVERR : RESP_OKAY;
	end

	assign o_awready = !aw_full;
	assign o_wready  = !w_full;
	assign o_bvalid  = bvalid_q;
	assign o_bresp   = bresp_q;

	assign wb.cyc   = cyc_q;
	assign wb.stb   = stb_q;
	assign wb.we    = 1'b1;
	assign wb.addr  = aw_word;
	assign wb.wdata = w_data;
	assign wb.sel   = w_strb;

endmodule

// ==== source/wb_arbiter.sv ====
// Round-robin arbiter joining the read and write Wishbone masters onto one bus
`timescale 1ns/1ps

module wb_arbiter (
	input  logic     i_clk,
	input  logic     i_reset,
	wb_bus_if.slave  rd,
	wb_bus_if.slave  wr,
	wb_bus_if.master mem
);

	// Low while the read bridge owns the bus
	logic owner_wr;
	logic owner_cyc;
	logic other_cyc;

	assign owner_cyc = owner_wr ? wr.cyc : rd.cyc;
	assign other_cyc = owner_wr ? rd.cyc : wr.cyc;

	// Hand over only while the owner holds no cycle
	// A released owner always loses to a waiting peer, so both alternate
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			owner_wr <= 1'b0;
		else if (!owner_cyc && other_cyc)
			owner_wr <= !owner_wr;
	end

	////////////////////
	// Request mux
	////////////////////

	assign mem.cyc   = owner_cyc;
	assign mem.stb   = owner_wr ? wr.stb   : rd.stb;
	assign mem.we    = owner_wr ? wr.we    : rd.we;
	assign mem.addr  = owner_wr ? wr.addr  : rd.addr;
	assign mem.wdata = owner_wr ? wr.wdata : rd.wdata;
	assign mem.sel   = owner_wr ? wr.sel   : rd.sel;

	////////////////////
	// Reply routing
	////////////////////

	assign rd.rdata = mem.rdata;
	assign wr.rdata = mem.rdata;

	// Non-owner is held off with stall and never sees a reply
	assign rd.ack   = mem.ack && !owner_wr;
	assign rd.err   = mem.err && !owner_wr;
	assign rd.stall = owner_wr || mem.stall;

	assign wr.ack   = mem.ack && owner_wr;
	assign wr.err   = mem.err && owner_wr;
	assign wr.stall = !owner_wr || mem.stall;

endmodule

// ==== source/wb_ram_slave.sv ====
// Wishbone block-RAM slave with byte selects and out-of-range error
`timescale 1ns/1ps

module wb_ram_slave
	import axil_pkg::*, wb_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_reset,
	wb_bus_if.slave wb
);

	axil_data_t mem [WB_MEM_WORDS];

	logic [$clog2(WB_MEM_WORDS)-1:0] word_idx;
	logic       req;
	logic       in_range;
	axil_data_t rdata_q;
	logic       ack_q;
	logic       err_q;

	assign req      = wb.cyc && wb.stb;
	assign in_range = (wb.addr < wb_addr_t'(WB_MEM_WORDS));
	assign word_idx = wb.addr[$clog2(WB_MEM_WORDS)-1:0];

	// Byte-lane writes, nothing written outside the RAM
	always_ff @(posedge i_clk)
	begin
		if (req && wb.we && in_range)
		begin
			for (int b = 0; b < AXIL_STRB_W; b++)
				if (wb.sel[b])
					mem[word_idx][8*b +: 8] <= wb.wdata[8*b +: 8];
		end
		if (req)
			rdata_q <= mem[word_idx];
	end

	// One reply per strobe, exactly one cycle later
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end
		else
		begin
			ack_q <= req && in_range;
			err_q <= req && !in_range;
		end
	end

	assign wb.stall = 1'b0;
	assign wb.ack   = ack_q;
	assign wb.err   = err_q;
	assign wb.rdata = rdata_q;

endmodule

// ==== source/axil_wb_top.sv ====
// Top level: AXI-lite read and write bridges, Wishbone arbiter and block RAM
`timescale 1ns/1ps

module axil_wb_top
	import axil_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset_n,
	// Read address and data channels
	input  axil_addr_t i_axi_araddr,
	input  logic       i_axi_arvalid,
	output logic       o_axi_arready,
	output axil_data_t o_axi_rdata,
	output axil_resp_t o_axi_rresp,
	output logic       o_axi_rvalid,
	input  logic       i_axi_rready,
	// Write address, data and response channels
	input  axil_addr_t i_axi_awaddr,
	input  logic       i_axi_awvalid,
	output logic       o_axi_awready,
	input  axil_data_t i_axi_wdata,
	input  axil_strb_t i_axi_wstrb,
	input  logic       i_axi_wvalid,
	output logic       o_axi_wready,
	output axil_resp_t o_axi_bresp,
	output logic       o_axi_bvalid,
	input  logic       i_axi_bready
);

	logic w_reset;

	assign w_reset = !i_reset_n;

	wb_bus_if rd_bus ();
	wb_bus_if wr_bus ();
	wb_bus_if mem_bus ();

	axil_rd_bridge u_rd_bridge (
		.i_clk     (i_clk),
		.i_reset   (w_reset),
		.i_araddr  (i_axi_araddr),
		.i_arvalid (i_axi_arvalid),
		.o_arready (o_axi_arready),
		.o_rdata   (o_axi_rdata),
		.o_rresp   (o_axi_rresp),
		.o_rvalid  (o_axi_rvalid),
		.i_rready  (i_axi_rready),
		.wb        (rd_bus)
	);

	axil_wr_bridge u_wr_bridge (
		.i_clk     (i_clk),
		.i_reset   (w_reset),
		.i_awaddr  (i_axi_awaddr),
		.i_awvalid (i_axi_awvalid),
		.o_awready (o_axi_awready),
		.i_wdata   (i_axi_wdata),
		.i_wstrb   (i_axi_wstrb),
		.i_wvalid  (i_axi_wvalid),
		.o_wready  (o_axi_wready),
		.o_bresp   (o_axi_bresp),
		.o_bvalid  (o_axi_bvalid),
		.i_bready  (i_axi_bready),
		.wb        (wr_bus)
	);

	// Both bridges share the RAM through the arbiter
	wb_arbiter u_arbiter (
		.i_clk   (i_clk),
		.i_reset (w_reset),
		.rd      (rd_bus),
		.wr      (wr_bus),
		.mem     (mem_bus)
	);

	wb_ram_slave u_ram (
		.i_clk   (i_clk),
		.i_reset (w_reset),
		.wb      (mem_bus)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock (20 ns period) and active-low reset held for 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_reset_n
);

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = !o_clk;
	end

	// Release on a falling edge like every other DUT input
	initial
	begin
		o_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_reset_n = 1'b1;
	end

endmodule

// ==== tb/axil_wb_tb.sv ====
// Testbench: memory reference model, AXI-lite stimulus, R compare process, checks, watchdog
`timescale 1ns/1ps

module axil_wb_tb
	import axil_pkg::*, wb_pkg::*;
();

	// Words 0..15 hold the main test data, 64..71 the concurrent writes
	localparam int N_WORDS      = 16;
	localparam int BURST_LEN    = 8;
	localparam int BURST_ROUNDS = 2;
	localparam int N_CONC       = 8;
	localparam int CONC_BASE    = 64;
	localparam int TOTAL_TXN    = 3 * N_WORDS + BURST_LEN * BURST_ROUNDS + 3 * N_CONC + 4;
	localparam int WATCHDOG_CYCLES = 16 + 200 * TOTAL_TXN;

	logic       clk;
	logic       reset_n;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic       rvalid;
	logic       rready = 1'b0;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic       wvalid;
	logic       wready;
	axil_resp_t bresp;
	logic       bvalid;
	logic       bready;

	integer seed = 32'h7d5b_2049;
	int     error_count = 0;

	// Reference memory and expected R stream in issue order
	axil_data_t ref_mem [WB_MEM_WORDS];
	axil_data_t exp_data_q [$];
	axil_resp_t exp_resp_q [$];

	axil_data_t exp_rdata;
	axil_resp_t exp_rresp;
	logic       r_held = 1'b0;
	axil_data_t held_data;
	axil_resp_t held_resp;

	tb_clock_gen clock_gen_i (
		.o_clk     (clk),
		.o_reset_n (reset_n)
	);

	axil_wb_top dut_i (
		.i_clk         (clk),
		.i_reset_n     (reset_n),
		.i_axi_araddr  (araddr),
		.i_axi_arvalid (arvalid),
		.o_axi_arready (arready),
		.o_axi_rdata   (rdata),
		.o_axi_rresp   (rresp),
		.o_axi_rvalid  (rvalid),
		.i_axi_rready  (rready),
		.i_axi_awaddr  (awaddr),
		.i_axi_awvalid (awvalid),
		.o_axi_awready (awready),
		.i_axi_wdata   (wdata),
		.i_axi_wstrb   (wstrb),
		.i_axi_wvalid  (wvalid),
		.o_axi_wready  (wready),
		.o_axi_bresp   (bresp),
		.o_axi_bvalid  (bvalid),
		.i_axi_bready  (bready)
	);

	////////////////////
	// Reference model
	////////////////////

	function automatic axil_data_t merge_word(input axil_data_t old_word,
		input axil_data_t new_word, input axil_strb_t strb);
		axil_data_t merged;
		merged = old_word;
		for (int b = 0; b < AXIL_STRB_W; b++)
			if (strb[b])
				merged[8*b +: 8] = new_word[8*b +: 8];
		return merged;
	endfunction

	// OKAY inside the RAM, SLVERR from the slave beyond it
	function automatic axil_resp_t expected_resp(input axil_addr_t addr);
		if (addr[AXIL_ADDR_W-1:2] < wb_addr_t'(WB_MEM_WORDS))
			return RESP_OKAY;
		return RESP_SLVERR;
	endfunction

	function automatic axil_addr_t word_addr(input int word);
		return axil_addr_t'(word) << 2;
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic abort_run();
		error_count++;
		$display("Testbench failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_data(input string name, input axil_data_t expected,
		input axil_data_t actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t expected,
		input axil_resp_t actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	////////////////////
	// Stimulus tasks, entered and left on a falling edge
	////////////////////

	// AW and W offered together, B accepted with random gaps
	// Readies are sampled on the falling edge, before the edge that transfers
	task automatic write_word(input axil_addr_t addr, input axil_data_t data,
		input axil_strb_t strb);
		logic       aw_done;
		logic       w_done;
		logic       b_done;
		axil_resp_t got_resp;
		aw_done  = 1'b0;
		w_done   = 1'b0;
		b_done   = 1'b0;
		got_resp = RESP_OKAY;
		awaddr   = addr;
		awvalid  = 1'b1;
		wdata    = data;
		wstrb    = strb;
		wvalid   = 1'b1;
		while (!(aw_done && w_done))
		begin
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			@(negedge clk);
			awvalid = !aw_done;
			wvalid  = !w_done;
		end
		while (!b_done)
		begin
			bready = ($random(seed) & 3) != 0;
			if (bvalid && bready)
			begin
				b_done   = 1'b1;
				got_resp = bresp;
			end
			@(negedge clk);
		end
		bready = 1'b0;
		check_resp("o_axi_bresp", expected_resp(addr), got_resp);
		if (expected_resp(addr) == RESP_OKAY)
			ref_mem[addr[9:2]] = merge_word(ref_mem[addr[9:2]], data, strb);
	endtask

	// Back-to-back calls keep arvalid high across addresses
	task automatic issue_read(input axil_addr_t addr);
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready)
			@(negedge clk);
		exp_data_q.push_back(ref_mem[addr[9:2]]);
		exp_resp_q.push_back(expected_resp(addr));
		@(negedge clk);
		arvalid = 1'b0;
	endtask

	task automatic drain_reads();
		while (exp_resp_q.size() != 0)
			@(negedge clk);
	endtask

	////////////////////
	// R compare process
	////////////////////

	// Random R backpressure, each beat checked on the falling edge before it transfers
	always @(negedge clk)
	begin
		if (!reset_n)
			rready = 1'b0;
		else
		begin
			// A stalled R beat must stay put
			if (r_held)
			begin
				check_flag("o_axi_rvalid", 1'b1, rvalid);
				check_data("o_axi_rdata", held_data, rdata);
				check_resp("o_axi_rresp", held_resp, rresp);
			end
			rready = ($random(seed) & 3) != 0;
			if (rvalid && rready)
			begin
				if (exp_resp_q.size() == 0)
				begin
					$display("An R response arrived at %0t ns with no read outstanding", $time);
					abort_run();
				end
				else
				begin
					exp_rdata = exp_data_q.pop_front();
					exp_rresp = exp_resp_q.pop_front();
					check_resp("o_axi_rresp", exp_rresp, rresp);
					if (exp_rresp == RESP_OKAY)
						check_data("o_axi_rdata", exp_rdata, rdata);
				end
			end
			r_held    = rvalid && !rready;
			held_data = rdata;
			held_resp = rresp;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
		abort_run();
	end

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		int i;
		int j;
		araddr  = '0;
		arvalid = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		@(posedge reset_n);
		@(negedge clk);

		check_flag("o_axi_arready", 1'b1, arready);
		check_flag("o_axi_awready", 1'b1, awready);
		check_flag("o_axi_wready", 1'b1, wready);
		check_flag("o_axi_rvalid", 1'b0, rvalid);
		check_flag("o_axi_bvalid", 1'b0, bvalid);

		// Full words first so every read hits known data
		for (i = 0; i < N_WORDS; i++)
			write_word(word_addr(i), axil_data_t'($random(seed)), 4'hf);
		for (i = 0; i < N_WORDS; i++)
			write_word(word_addr($random(seed) & (N_WORDS - 1)),
				axil_data_t'($random(seed)), axil_strb_t'($random(seed)));
		for (i = 0; i < N_WORDS; i++)
			issue_read(word_addr(i));
		drain_reads();

		for (j = 0; j < BURST_ROUNDS; j++)
		begin
			for (i = 0; i < BURST_LEN; i++)
				issue_read(word_addr($random(seed) & (N_WORDS - 1)));
			drain_reads();
		end

		// Both bridges compete for the RAM on disjoint words
		fork
			begin
				for (i = 0; i < N_CONC; i++)
					write_word(word_addr(CONC_BASE + i), axil_data_t'($random(seed)), 4'hf);
			end
			begin
				for (j = 0; j < N_CONC; j++)
					issue_read(word_addr($random(seed) & (N_WORDS - 1)));
			end
		join
		drain_reads();
		for (i = 0; i < N_CONC; i++)
			issue_read(word_addr(CONC_BASE + i));
		drain_reads();

		// Word 0x105 aliases word 5 in the RAM index bits
		write_word(word_addr(32'h105), axil_data_t'($random(seed)), 4'hf);
		issue_read(word_addr(5));
		drain_reads();
		issue_read(word_addr(32'h30_0000));
		drain_reads();
		issue_read(word_addr(7));
		drain_reads();

		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== compile.f ====
source/axil_pkg.sv
source/wb_pkg.sv
source/wb_bus_if.sv
source/axil_rd_bridge.sv
source/axil_wr_bridge.sv
source/wb_arbiter.sv
source/wb_ram_slave.sv
source/axil_wb_top.sv
tb/tb_clock_gen.sv
tb/axil_wb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the AXI-lite to Wishbone testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --timescale 1ns/1ps --top-module axil_wb_tb \
	-f compile.f -o axil_wb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/axil_wb_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "Testbench passed"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
